// File: include/mexp_params.svh
// Global sizing constants for the element-wise matrix exponential unit
`ifndef MEXP_PARAMS_SVH
`define MEXP_PARAMS_SVH

//////////////////////////////
// Fixed-point format
//////////////////////////////

// Total width of one signed value
`define MEXP_DATA_WIDTH 16

// Fraction bits, so 1.0 is 0x0100
`define MEXP_FRAC_BITS 8

//////////////////////////////
// Series and matrix limits
//////////////////////////////

// Taylor terms including the constant term
`define MEXP_TERM_COUNT 8

// Row and column count width, sizes 1 to 15
`define MEXP_INDEX_WIDTH 4

`endif

// File: logic/mexp_pkg.sv
// Shared types of the matrix exponential unit
package mexp_pkg;

  `include "mexp_params.svh"

  //////////////////////////////
  // Data types
  //////////////////////////////

  // One signed fixed-point word
  typedef logic signed [`MEXP_DATA_WIDTH-1:0] fixed_t;

  // Matrix sizes and loop counters
  typedef logic [`MEXP_INDEX_WIDTH-1:0] index_t;

  //////////////////////////////
  // Control types
  //////////////////////////////

  // Sequencer FSM states
  typedef enum logic [1:0] {
    seq_idle,
    seq_expect_row,
    seq_expect_col,
    seq_busy
  } seq_state_t;

endpackage

// File: logic/taylor_exp_core.sv
// Iterative fixed-point Taylor series evaluation of e^x, one term per cycle
`timescale 1ns/1ps

`include "mexp_params.svh"

module taylor_exp_core
  import mexp_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  input  logic   launch,
  input  fixed_t operand,
  output logic   done,
  output fixed_t result
);

  //////////////////////////////
  // Constants
  //////////////////////////////

  localparam int     data_w = `MEXP_DATA_WIDTH;
  localparam int     idx_w  = `MEXP_INDEX_WIDTH;
  // Fixed-point 1.0
  localparam fixed_t one    = fixed_t'(1 << `MEXP_FRAC_BITS);
  // Index of the final term
  localparam index_t last_k = index_t'(`MEXP_TERM_COUNT - 1);

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic   busy_q;
  index_t k_q;

  // Operand and running series
  fixed_t x_q;
  fixed_t term_q;
  fixed_t sum_q;

  // Double-width datapath for one term
  logic signed [2*data_w-1:0] product;
  logic signed [2*data_w-1:0] scaled;
  logic signed [2*data_w-1:0] divisor;
  logic signed [2*data_w-1:0] quotient;

  fixed_t term_next;
  fixed_t sum_next;

  //////////////////////////////
  // Term datapath
  //////////////////////////////

  always_comb begin
    // term_k = (term_(k-1) * x >>> frac) / k
    product   = term_q * x_q;
    scaled    = product >>> `MEXP_FRAC_BITS;
    divisor   = {{(2*data_w-idx_w){1'b0}}, k_q};
    // Signed divide truncates toward zero
    quotient  = scaled / divisor;
    term_next = quotient[data_w-1:0];
    // Sum wraps at the word width
    sum_next  = sum_q + term_next;
  end

  //////////////////////////////
  // Iteration control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q <= 1'b0;
      k_q    <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (launch) begin
        // Load cycle, first term next
        busy_q <= 1'b1;
        k_q    <= index_t'(1);
      end else if (busy_q) begin
        k_q <= index_t'(k_q + 1'b1);
        if (k_q == last_k) begin
          busy_q <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  // Series registers
  always_ff @(posedge CLK) begin
    if (launch) begin
      x_q    <= operand;
      term_q <= one;
      sum_q  <= one;
    end else if (busy_q) begin
      term_q <= term_next;
      sum_q  <= sum_next;
      if (k_q == last_k) begin
        result <= sum_next;
      end
    end
  end

endmodule

// File: logic/vector_exp_unit.sv
// Per-row column tracking that launches the Taylor core and tags the row end
`timescale 1ns/1ps

module vector_exp_unit
  import mexp_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  // Job start with the row length
  input  logic   start,
  input  index_t size_j,
  // Element from the sequencer
  input  logic   elem_valid,
  input  fixed_t elem_data,
  input  logic   row_first,
  // Core return path
  input  logic   done,
  input  fixed_t result,
  // Core launch
  output logic   launch,
  output fixed_t operand,
  // Result toward the sequencer
  output logic   res_valid,
  output fixed_t res_data,
  output logic   row_last
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Columns per row, latched on start
  index_t size_j_q;

  // Column of the element in flight
  index_t col_q;
  index_t col_next;

  // Row-end flag for the element in flight
  logic   last_q;

  //////////////////////////////
  // Column counter
  //////////////////////////////

  // Row start goes back to column zero
  assign col_next = row_first ? '0 : index_t'(col_q + 1'b1);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_j_q <= '0;
      col_q    <= '0;
      last_q   <= 1'b0;
    end else begin
      if (start) begin
        size_j_q <= size_j;
      end
      if (elem_valid) begin
        col_q  <= col_next;
        last_q <= (col_next == index_t'(size_j_q - 1'b1));
      end else if (done) begin
        // Flag is spent once the result is out
        last_q <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Core hand-off
  //////////////////////////////

  // Launch in the same cycle as the element
  assign launch    = elem_valid;
  assign operand   = elem_data;

  // Result goes straight back with its row tag
  assign res_valid = done;
  assign res_data  = result;
  assign row_last  = last_q;

endmodule

// File: logic/matrix_exp_sequencer.sv
// Input sequencer that checks strobe order and drives the result strobes of the unit
`timescale 1ns/1ps

module matrix_exp_sequencer
  import mexp_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  // Job control from the host
  input  logic   start,
  input  index_t size_i,
  // Element strobes from the host
  input  logic   data_in_i_enable,
  input  logic   data_in_j_enable,
  input  fixed_t data_in,
  // Result side of the vector unit
  input  logic   res_valid,
  input  fixed_t res_data,
  input  logic   row_last,
  // Element toward the vector unit
  output logic   elem_valid,
  output fixed_t elem_data,
  output logic   row_first,
  // Result strobes to the host
  output logic   ready,
  output fixed_t data_out,
  output logic   data_out_i_enable,
  output logic   data_out_j_enable
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // FSM state
  seq_state_t state_q;

  // Row count latched on start
  index_t size_i_q;

  // Current row of the job
  index_t row_q;

  // Strobe that matches the expected position
  logic   accept_row;
  logic   accept_col;

  // Result of the final row
  logic   last_row;

  //////////////////////////////
  // Strobe qualification
  //////////////////////////////

  // i-strobe only when a row start is due
  assign accept_row = (state_q == seq_expect_row) && data_in_i_enable;

  // j-strobe only inside a row
  assign accept_col = (state_q == seq_expect_col) && data_in_j_enable;

  assign last_row = (row_q == index_t'(size_i_q - 1'b1));

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q           <= seq_idle;
      size_i_q          <= '0;
      row_q             <= '0;
      elem_valid        <= 1'b0;
      row_first         <= 1'b0;
      ready             <= 1'b0;
      data_out          <= '0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
    end else begin
      // All strobes are single-cycle pulses
      elem_valid        <= 1'b0;
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;

      case (state_q)
        seq_idle: begin
          if (start) begin
            size_i_q <= size_i;
            row_q    <= '0;
            state_q  <= seq_expect_row;
          end
        end
        seq_expect_row: begin
          // First element of a row restarts the column count
          if (accept_row) begin
            elem_valid <= 1'b1;
            row_first  <= 1'b1;
            state_q    <= seq_busy;
          end
        end
        seq_expect_col: begin
          if (accept_col) begin
            elem_valid <= 1'b1;
            row_first  <= 1'b0;
            state_q    <= seq_busy;
          end
        end
        seq_busy: begin
          // Strobes seen here are dropped
          if (res_valid) begin
            data_out          <= res_data;
            data_out_j_enable <= 1'b1;
            if (!row_last) begin
              state_q <= seq_expect_col;
            end else if (last_row) begin
              // End of job
              ready   <= 1'b1;
              state_q <= seq_idle;
            end else begin
              data_out_i_enable <= 1'b1;
              row_q             <= index_t'(row_q + 1'b1);
              state_q           <= seq_expect_row;
            end
          end
        end
        default: begin
          state_q <= seq_idle;
        end
      endcase
    end
  end

  //////////////////////////////
  // Element register
  //////////////////////////////

  // Operand captured with the accepted strobe
  always_ff @(posedge CLK) begin
    if (accept_row || accept_col) begin
      elem_data <= data_in;
    end
  end

endmodule

// File: logic/matrix_exp_top.sv
// Top level of the element-wise matrix exponential unit
`timescale 1ns/1ps

module matrix_exp_top
  import mexp_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  input  logic   start,
  input  index_t size_i,
  input  index_t size_j,
  input  fixed_t data_in,
  input  logic   data_in_i_enable,
  input  logic   data_in_j_enable,
  output logic   ready,
  output fixed_t data_out,
  output logic   data_out_i_enable,
  output logic   data_out_j_enable
);

  // Sequencer to vector unit
  logic   elem_valid;
  fixed_t elem_data;
  logic   row_first;

  // Vector unit to core and back
  logic   launch;
  fixed_t operand;
  logic   done;
  fixed_t result;

  // Results back to the sequencer
  logic   res_valid;
  fixed_t res_data;
  logic   row_last;

  matrix_exp_sequencer i_sequencer (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_i           (size_i),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .data_in          (data_in),
    .res_valid        (res_valid),
    .res_data         (res_data),
    .row_last         (row_last),
    .elem_valid       (elem_valid),
    .elem_data        (elem_data),
    .row_first        (row_first),
    .ready            (ready),
    .data_out         (data_out),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable)
  );

  vector_exp_unit i_vector_unit (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .size_j    (size_j),
    .elem_valid(elem_valid),
    .elem_data (elem_data),
    .row_first (row_first),
    .done      (done),
    .result    (result),
    .launch    (launch),
    .operand   (operand),
    .res_valid (res_valid),
    .res_data  (res_data),
    .row_last  (row_last)
  );

  taylor_exp_core i_taylor_core (
    .CLK    (CLK),
    .RST    (RST),
    .launch (launch),
    .operand(operand),
    .done   (done),
    .result (result)
  );

endmodule

// File: tb/matrix_exp_checker.sv
// Protocol assertions on the result strobes of the matrix exponential unit
`timescale 1ns/1ps

`include "mexp_params.svh"

module matrix_exp_checker
  import mexp_pkg::*;
(
  input logic CLK,
  input logic RST,
  // Registered element toward the vector unit, one cycle after an accepted strobe
  input logic elem_valid,
  // Result strobes of the top level
  input logic ready,
  input logic data_out_i_enable,
  input logic data_out_j_enable
);

  // elem_valid to data_out_j_enable, one less than the strobe-to-result latency
  localparam int result_delay = `MEXP_TERM_COUNT + 1;

  //////////////////////////////
  // Strobe grouping
  //////////////////////////////

  ready_with_result: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_j_enable)
    else $error("ready asserted without data_out_j_enable");

  row_end_with_result: assert property (@(posedge CLK) disable iff (RST)
    data_out_i_enable |-> data_out_j_enable)
    else $error("data_out_i_enable asserted without data_out_j_enable");

  //////////////////////////////
  // Single-cycle pulses
  //////////////////////////////

  ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("ready held longer than one cycle");

  row_end_pulse: assert property (@(posedge CLK) disable iff (RST)
    data_out_i_enable |=> !data_out_i_enable)
    else $error("data_out_i_enable held longer than one cycle");

  result_pulse: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |=> !data_out_j_enable)
    else $error("data_out_j_enable held longer than one cycle");

  //////////////////////////////
  // Fixed latency
  //////////////////////////////

  // Every result traces back to one launched element
  result_latency: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |-> $past(elem_valid, result_delay))
    else $error("result strobe without an element at the fixed latency");

endmodule

// File: tb/matrix_exp_tb.sv
// Directed testbench for the element-wise matrix exponential unit
`timescale 1ns/1ps

`include "mexp_params.svh"

module matrix_exp_tb
  import mexp_pkg::*;
();

  // Input strobe sampled to data_out_j_enable sampled
  localparam int latency    = `MEXP_TERM_COUNT + 2;
  localparam int wait_limit = 40;

  logic   CLK;
  logic   RST;
  logic   start;
  index_t size_i;
  index_t size_j;
  fixed_t data_in;
  logic   data_in_i_enable;
  logic   data_in_j_enable;
  logic   ready;
  fixed_t data_out;
  logic   data_out_i_enable;
  logic   data_out_j_enable;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     test_err_base;

  matrix_exp_top i_matrix_exp_top (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_i           (size_i),
    .size_j           (size_j),
    .data_in          (data_in),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .ready            (ready),
    .data_out         (data_out),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable)
  );

  bind matrix_exp_top matrix_exp_checker i_checker (
    .CLK              (CLK),
    .RST              (RST),
    .elem_valid       (elem_valid),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable)
  );

  // 4 ns clock
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Truncated series with term_k = ((term_(k-1) * x) >>> frac) / k and 16-bit wrap on the sum
  function automatic fixed_t exp_model(input fixed_t x);
    fixed_t term;
    fixed_t sum;
    int     p;
    term = fixed_t'(1 << `MEXP_FRAC_BITS);
    sum  = term;
    for (int k = 1; k < `MEXP_TERM_COUNT; k++) begin
      p    = int'(term) * int'(x);
      p    = p >>> `MEXP_FRAC_BITS;
      // Integer divide truncates toward zero
      p    = p / k;
      term = fixed_t'(p);
      sum  = fixed_t'(sum + term);
    end
    return sum;
  endfunction

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected);
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  task automatic start_job(input index_t rows, input index_t cols);
    @(posedge CLK);
    start  <= 1'b1;
    size_i <= rows;
    size_j <= cols;
    @(posedge CLK);
    start  <= 1'b0;
  endtask

  // One-cycle strobe with no result expected
  task automatic pulse_strobe(input fixed_t x, input logic row_start);
    @(posedge CLK);
    data_in          <= x;
    data_in_i_enable <= row_start;
    data_in_j_enable <= !row_start;
    @(posedge CLK);
    data_in_i_enable <= 1'b0;
    data_in_j_enable <= 1'b0;
  endtask

  task automatic expect_quiet(input int n);
    checks++;
    for (int c = 0; c < n; c++) begin
      @(posedge CLK);
      if (data_out_j_enable || data_out_i_enable || ready) begin
        errors++;
        $display("ERROR: result strobe seen %0d cycles into a quiet period", c + 1);
      end
    end
  endtask

  // Sends one element and checks its result; poke adds j and i strobes while busy
  task automatic send_and_check(input fixed_t x, input logic row_start,
                                input logic exp_row_end, input logic exp_ready,
                                input logic poke);
    int     cycles;
    logic   seen;
    fixed_t expected;
    expected = exp_model(x);
    seen     = 1'b0;
    cycles   = 0;
    @(posedge CLK);
    data_in          <= x;
    data_in_i_enable <= row_start;
    data_in_j_enable <= !row_start;
    @(posedge CLK);
    data_in_i_enable <= 1'b0;
    data_in_j_enable <= 1'b0;
    while (!seen && cycles < wait_limit) begin
      @(posedge CLK);
      cycles++;
      if (poke && cycles == 2) begin
        data_in          <= 16'sh0180;
        data_in_j_enable <= 1'b1;
      end else if (poke && cycles == 3) begin
        data_in_j_enable <= 1'b0;
        data_in_i_enable <= 1'b1;
      end else if (poke && cycles == 4) begin
        data_in_i_enable <= 1'b0;
      end
      seen = data_out_j_enable;
    end
    if (!seen) begin
      errors++;
      $display("ERROR: no result within %0d cycles for input 0x%h", wait_limit, x);
    end else begin
      compare("data_out", data_out, expected);
      compare("data_out_i_enable", 16'(data_out_i_enable), 16'(exp_row_end));
      compare("ready", 16'(ready), 16'(exp_ready));
      checks++;
      if (cycles != latency) begin
        errors++;
        $display("ERROR: result came %0d cycles after the strobe instead of %0d",
                 cycles, latency);
      end
    end
  endtask

  // Whole job with random elements in +-2.0 sent row by row
  task automatic run_job(input index_t rows, input index_t cols);
    fixed_t x;
    logic   last_col;
    logic   last_row;
    start_job(rows, cols);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        x        = fixed_t'($random(seed) % 513);
        last_col = (c == cols - 1);
        last_row = (r == rows - 1);
        send_and_check(x, c == 0, last_col && !last_row, last_col && last_row, 1'b0);
      end
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    compare("ready", 16'(ready), 16'h0);
    compare("data_out_i_enable", 16'(data_out_i_enable), 16'h0);
    compare("data_out_j_enable", 16'(data_out_j_enable), 16'h0);
    compare("data_out", data_out, 16'h0);
    expect_quiet(20);
    end_test("reset state");
  endtask

  task automatic test_single_element();
    start_job(4'd1, 4'd1);
    send_and_check(16'sh0000, 1'b1, 1'b0, 1'b1, 1'b0);
    // e^0 is exactly 1.0
    compare("data_out", data_out, 16'h0100);
    start_job(4'd1, 4'd1);
    send_and_check(16'sh0100, 1'b1, 1'b0, 1'b1, 1'b0);
    end_test("single element");
  endtask

  task automatic test_full_matrix();
    run_job(4'd3, 4'd4);
    end_test("full matrix values and strobes");
  endtask

  task automatic test_ordering();
    start_job(4'd1, 4'd2);
    // j-strobe where a row start is due
    pulse_strobe(16'sh0080, 1'b0);
    expect_quiet(14);
    send_and_check(16'sh0040, 1'b1, 1'b0, 1'b0, 1'b1);
    // Strobes seen while busy leave no second result
    expect_quiet(14);
    send_and_check(fixed_t'(-192), 1'b0, 1'b0, 1'b1, 1'b0);
    end_test("ordering rules");
  endtask

  task automatic test_back_to_back();
    run_job(4'd2, 4'd2);
    run_job(4'd1, 4'd3);
    end_test("back-to-back jobs");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed             = 32'hb603_a280;
    errors           = 0;
    checks           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    test_err_base    = 0;
    RST              = 1'b1;
    start            = 1'b0;
    size_i           = '0;
    size_j           = '0;
    data_in          = '0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    repeat (16) @(posedge CLK);
    RST <= 1'b0;
    test_reset_state();
    test_single_element();
    test_full_matrix();
    test_ordering();
    test_back_to_back();
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
logic/mexp_pkg.sv
logic/taylor_exp_core.sv
logic/vector_exp_unit.sv
logic/matrix_exp_sequencer.sv
logic/matrix_exp_top.sv
tb/matrix_exp_checker.sv
tb/matrix_exp_tb.sv

// File: Makefile
# Verilator build, run and lint for the matrix exponential unit

VERILATOR ?= verilator
TOP       ?= matrix_exp_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= RESULT: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

# Pass or fail comes from the log, not the exit status of the pipe
run: build
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
